//--- hw/pmu_settings.svh
// PMU sizing macros for counter width, counter count and crossbar geometry
`ifndef PMU_SETTINGS_SVH
`define PMU_SETTINGS_SVH

// ------------------------------
// Counter bank sizes
// ------------------------------

// Width of one counter and of the quota limit
`define PMU_REG_WIDTH 32

// Number of event counters in the bank
`define PMU_N_COUNTERS 9

// ------------------------------
// Crossbar sizes
// ------------------------------

// SoC event lines entering the crossbar
`define PMU_N_SOC_EV 32

// Bits in one select field
// log2 of the SoC event line count
`define PMU_SEL_BITS 5

`endif

//--- hw/pmu_pkg.sv
// PMU shared types for self-test modes, configuration structs and counter vectors
`default_nettype none

`include "pmu_settings.svh"

package pmu_pkg;

    // ------------------------------
    // Self-test override modes
    // ------------------------------

    // Mode applied after the crossbar register
    typedef enum logic [1:0] {
        // Crossbar output passes unchanged
        SELFTEST_OFF     = 2'b00,
        // Every counter event forced high
        SELFTEST_ALL_ON  = 2'b01,
        // Every counter event forced low
        SELFTEST_ALL_OFF = 2'b10,
        // Counter 0 high, the rest low
        SELFTEST_ONE_ON  = 2'b11
    } selftest_e;

    // ------------------------------
    // Data types
    // ------------------------------

    // One counter value
    typedef logic [`PMU_REG_WIDTH-1:0] counter_t;

    // Whole counter bank, counter k in slice k
    typedef logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counter_vec_t;

    // One bit per counter
    typedef logic [`PMU_N_COUNTERS-1:0] event_vec_t;

    // Raw SoC event lines
    typedef logic [`PMU_N_SOC_EV-1:0] soc_event_t;

    // ------------------------------
    // Configuration types
    // ------------------------------

    // Field k names the SoC line feeding counter k
    typedef logic [`PMU_N_COUNTERS-1:0][`PMU_SEL_BITS-1:0] crossbar_cfg_t;

    // Count stage controls
    typedef struct packed {
        // Counting enable
        logic en;
        // Clears the whole bank
        logic softrst;
    } count_cfg_t;

    // Interrupt stage controls and parameters
    typedef struct packed {
        logic       overflow_en;
        logic       overflow_softrst;
        logic       quota_softrst;
        // Vector bits allowed to raise the overflow interrupt
        event_vec_t overflow_mask;
        // Counters taking part in the quota sum
        event_vec_t quota_mask;
        counter_t   quota_limit;
    } irq_cfg_t;

endpackage

`default_nettype wire

//--- hw/pmu_event_select.sv
// PMU event select stage, registered SoC event crossbar with self-test override
`default_nettype none

`include "pmu_settings.svh"

module pmu_event_select (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    // Raw SoC event lines
    input  wire pmu_pkg::soc_event_t    events_i,
    // Per-counter select fields
    input  wire pmu_pkg::crossbar_cfg_t xbar_cfg_i,
    // Override mode, applied after the register
    input  wire pmu_pkg::selftest_e     selftest_i,
    // One event bit per counter
    output pmu_pkg::event_vec_t         cnt_events_o
);

    import pmu_pkg::*;

    // ------------------------------
    // Crossbar
    // ------------------------------

    // Picked SoC line per counter, before the register
    event_vec_t xbar_d;
    // Crossbar register
    event_vec_t xbar_q;

    // One 32-to-1 mux per counter
    always_comb begin
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            xbar_d[k] = events_i[xbar_cfg_i[k]];
        end
    end

    // Single register stage
    // Event in the cycle before edge N shows after edge N
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            xbar_q <= '0;
        end else begin
            xbar_q <= xbar_d;
        end
    end

    // ------------------------------
    // Self-test override
    // ------------------------------

    // Combinational, so a mode change is seen at once by the counters
    always_comb begin
        case (selftest_i)
            SELFTEST_OFF: begin
                cnt_events_o = xbar_q;
            end
            SELFTEST_ALL_ON: begin
                cnt_events_o = '1;
            end
            SELFTEST_ALL_OFF: begin
                cnt_events_o = '0;
            end
            SELFTEST_ONE_ON: begin
                // Counter 0 only
                cnt_events_o    = '0;
                cnt_events_o[0] = 1'b1;
            end
            default: begin
                cnt_events_o = xbar_q;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/pmu_counters.sv
// PMU count stage, bank of event counters with enable, soft clear and external load
`default_nettype none

`include "pmu_settings.svh"

module pmu_counters (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    // One increment request per counter
    input  wire pmu_pkg::event_vec_t     cnt_events_i,
    // Enable and soft reset levels
    input  wire pmu_pkg::count_cfg_t     count_cfg_i,
    // Load strobe, one cycle
    input  wire                      we_i,
    // Values taken on a load
    input  wire pmu_pkg::counter_vec_t   counters_i,
    // Current counter values
    output pmu_pkg::counter_vec_t        counters_o
);

    import pmu_pkg::*;

    // ------------------------------
    // Counter bank
    // ------------------------------

    // Counter registers
    counter_vec_t cnt_q;
    // Next value of every counter
    counter_vec_t cnt_d;

    // Priority is load, then soft clear, then count
    always_comb begin
        cnt_d = cnt_q;
        if (we_i) begin
            cnt_d = counters_i;
        end else if (count_cfg_i.softrst) begin
            cnt_d = '0;
        end else if (count_cfg_i.en) begin
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                // Wraps from all ones back to zero
                if (cnt_events_i[k]) begin
                    cnt_d[k] = cnt_q[k] + counter_t'(1);
                end
            end
        end
    end

    // Bank update
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // Read-back and feed to the interrupt stage
    assign counters_o = cnt_q;

endmodule

`default_nettype wire

//--- hw/pmu_irq.sv
// PMU interrupt stage, sticky overflow vector with masked interrupt and quota check
`default_nettype none

`include "pmu_settings.svh"

module pmu_irq (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    // Counter values from the count stage
    input  wire pmu_pkg::counter_vec_t  counters_i,
    // Enables, soft resets, masks and quota limit
    input  wire pmu_pkg::irq_cfg_t      irq_cfg_i,
    // Sticky per-counter overflow flags
    output pmu_pkg::event_vec_t         overflow_vect_o,
    output logic                    intr_overflow_o,
    output logic                    intr_quota_o
);

    import pmu_pkg::*;

    // Sum width, enough for every counter at all ones
    localparam int SUM_W = `PMU_REG_WIDTH + $clog2(`PMU_N_COUNTERS);

    // ------------------------------
    // Overflow
    // ------------------------------

    // Counters sitting at all ones this cycle
    event_vec_t counter_full;
    // Sticky overflow flags
    event_vec_t overflow_vect_q;
    // Overflow interrupt register
    logic       intr_overflow_q;

    always_comb begin
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            counter_full[k] = &counters_i[k];
        end
    end

    // Bit k set the edge after counter k reaches all ones
    // Held until software clears it
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            overflow_vect_q <= '0;
        end else if (irq_cfg_i.overflow_softrst) begin
            overflow_vect_q <= '0;
        end else if (irq_cfg_i.overflow_en) begin
            overflow_vect_q <= overflow_vect_q | counter_full;
        end
    end

    // One edge behind the vector, masked
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            intr_overflow_q <= 1'b0;
        end else if (irq_cfg_i.overflow_softrst) begin
            intr_overflow_q <= 1'b0;
        end else begin
            intr_overflow_q <= |(overflow_vect_q & irq_cfg_i.overflow_mask);
        end
    end

    // ------------------------------
    // Quota
    // ------------------------------

    // Sum of the counters under the quota mask
    logic [SUM_W-1:0] quota_sum;
    // Quota interrupt register
    logic             intr_quota_q;

    // Widened adds, no wrap on the 32-bit counters
    always_comb begin
        quota_sum = '0;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            if (irq_cfg_i.quota_mask[k]) begin
                quota_sum = quota_sum + SUM_W'(counters_i[k]);
            end
        end
    end

    // Latched once the limit is passed
    // Cleared only by the quota soft reset
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            intr_quota_q <= 1'b0;
        end else if (irq_cfg_i.quota_softrst) begin
            intr_quota_q <= 1'b0;
        end else if (quota_sum > SUM_W'(irq_cfg_i.quota_limit)) begin
            intr_quota_q <= 1'b1;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign overflow_vect_o = overflow_vect_q;
    assign intr_overflow_o = intr_overflow_q;
    assign intr_quota_o    = intr_quota_q;

endmodule

`default_nettype wire

//--- hw/pmu_top.sv
// PMU top level, chains event select, counter bank and interrupt stages
`default_nettype none

module pmu_top (
    input  wire                     clk_i,
    input  wire                     rstn_i,
    // SoC event lines
    input  wire pmu_pkg::soc_event_t    events_i,
    // Crossbar select fields
    input  wire pmu_pkg::crossbar_cfg_t xbar_cfg_i,
    // Self-test override mode
    input  wire pmu_pkg::selftest_e     selftest_i,
    // Counter enable and soft reset
    input  wire pmu_pkg::count_cfg_t    count_cfg_i,
    // Interrupt controls, masks and limit
    input  wire pmu_pkg::irq_cfg_t      irq_cfg_i,
    // Counter load strobe and data
    input  wire                     we_i,
    input  wire pmu_pkg::counter_vec_t  counters_i,
    // Counter read-back
    output wire pmu_pkg::counter_vec_t  counters_o,
    // Sticky overflow flags
    output wire pmu_pkg::event_vec_t    overflow_vect_o,
    output wire                     intr_overflow_o,
    output wire                     intr_quota_o
);

    import pmu_pkg::*;

    // Selected and overridden events into the counters
    event_vec_t cnt_events;

    // ------------------------------
    // Stage 1, event select
    // ------------------------------
    pmu_event_select u_event_select (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events_i),
        .xbar_cfg_i   (xbar_cfg_i),
        .selftest_i   (selftest_i),
        .cnt_events_o (cnt_events)
    );

    // ------------------------------
    // Stage 2, counter bank
    // ------------------------------
    pmu_counters u_counters (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cnt_events_i (cnt_events),
        .count_cfg_i  (count_cfg_i),
        .we_i         (we_i),
        .counters_i   (counters_i),
        .counters_o   (counters_o)
    );

    // ------------------------------
    // Stage 3, interrupts
    // ------------------------------
    // Reads the same counter values that software sees
    pmu_irq u_irq (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .counters_i      (counters_o),
        .irq_cfg_i       (irq_cfg_i),
        .overflow_vect_o (overflow_vect_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_pmu.sv
// PMU directed testbench for routing, self-test, load, overflow and quota interrupts
`default_nettype none

`include "pmu_settings.svh"

module tb_pmu;

    import pmu_pkg::*;

    // Run limit in clock cycles
    localparam int MAX_CYCLES = 2000;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    // All ones minus 3, overflows on the fourth increment
    localparam counter_t NEAR_FULL = ~counter_t'(3);

    logic          clk_i;
    logic          rstn_i;
    soc_event_t    events_i;
    crossbar_cfg_t xbar_cfg_i;
    selftest_e     selftest_i;
    count_cfg_t    count_cfg_i;
    irq_cfg_t      irq_cfg_i;
    logic          we_i;
    counter_vec_t  counters_i;
    counter_vec_t  counters_o;
    event_vec_t    overflow_vect_o;
    logic          intr_overflow_o;
    logic          intr_quota_o;

    // Random source state
    logic [31:0] lfsr_state;
    // Cycles since time zero
    int unsigned cycle_cnt = 0;

    pmu_top dut0 (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .events_i        (events_i),
        .xbar_cfg_i      (xbar_cfg_i),
        .selftest_i      (selftest_i),
        .count_cfg_i     (count_cfg_i),
        .irq_cfg_i       (irq_cfg_i),
        .we_i            (we_i),
        .counters_i      (counters_i),
        .counters_o      (counters_o),
        .overflow_vect_o (overflow_vect_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    // ------------------------------
    // Clock and timeout
    // ------------------------------

    // Period 100
    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped after the cycle limit");
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // One right shift of the Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // Collects n bits, one LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // SoC line routed to counter k in the routing test
    function automatic int routed_line(input int k);
        return (3 * k + 1) % `PMU_N_SOC_EV;
    endfunction

    // Inputs change just after the falling edge
    task automatic tick();
        @(negedge clk_i);
    endtask

    task automatic check_counter(input string name, input counter_t exp, input counter_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "counter mismatch");
        end
    endtask

    task automatic check_events(input string name, input event_vec_t exp,
                                input event_vec_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "event vector mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "interrupt line mismatch");
        end
    endtask

    // Whole bank against a model
    task automatic compare_bank(input counter_vec_t exp);
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            check_counter($sformatf("counters_o[%0d]", k), exp[k], counters_o[k]);
        end
    endtask

    // One-cycle load strobe
    task automatic load_bank(input counter_vec_t vals);
        counters_i = vals;
        we_i       = 1'b1;
        tick();
        we_i       = 1'b0;
        counters_i = '0;
    endtask

    // One-cycle soft reset of the counters
    task automatic clear_bank();
        count_cfg_i.softrst = 1'b1;
        tick();
        count_cfg_i.softrst = 1'b0;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic verify_reset_state();
        compare_bank('0);
        check_events("overflow_vect_o", '0, overflow_vect_o);
        check_bit("intr_overflow_o", 1'b0, intr_overflow_o);
        check_bit("intr_quota_o", 1'b0, intr_quota_o);
    endtask

    // Random events through the crossbar, counted by a local model
    task automatic crossbar_routing();
        counter_vec_t exp;
        logic [31:0]  ev;
        exp = '0;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            xbar_cfg_i[k] = `PMU_SEL_BITS'(routed_line(k));
        end
        selftest_i     = SELFTEST_OFF;
        count_cfg_i.en = 1'b1;
        for (int c = 0; c < 40; c++) begin
            take_bits(32, ev);
            events_i = ev;
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                if (ev[routed_line(k)]) begin
                    exp[k] = exp[k] + counter_t'(1);
                end
            end
            tick();
        end
        events_i = '0;
        // Register stage plus count stage
        tick();
        tick();
        compare_bank(exp);
        count_cfg_i.en = 1'b0;
    endtask

    task automatic selftest_modes();
        selftest_e    modes [3];
        counter_vec_t exp;
        modes = '{SELFTEST_ALL_ON, SELFTEST_ALL_OFF, SELFTEST_ONE_ON};
        clear_bank();
        compare_bank('0);
        for (int m = 0; m < 3; m++) begin
            selftest_i     = modes[m];
            count_cfg_i.en = 1'b1;
            repeat (10) tick();
            count_cfg_i.en = 1'b0;
            exp = '0;
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                if (modes[m] == SELFTEST_ALL_ON || (modes[m] == SELFTEST_ONE_ON && k == 0)) begin
                    exp[k] = counter_t'(10);
                end
            end
            compare_bank(exp);
            clear_bank();
            compare_bank('0);
        end
        selftest_i = SELFTEST_OFF;
    endtask

    task automatic load_and_enable();
        counter_vec_t vals;
        logic [31:0]  r;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            take_bits(32, r);
            vals[k] = r;
        end
        load_bank(vals);
        compare_bank(vals);
        // Forced events but counting disabled
        selftest_i     = SELFTEST_ALL_ON;
        count_cfg_i.en = 1'b0;
        repeat (5) tick();
        compare_bank(vals);
        selftest_i = SELFTEST_OFF;
    endtask

    task automatic overflow_irq();
        counter_vec_t vals;
        event_vec_t   exp_vec;
        vals    = '0;
        vals[2] = NEAR_FULL;
        vals[5] = NEAR_FULL;
        load_bank(vals);
        irq_cfg_i.overflow_en      = 1'b1;
        irq_cfg_i.overflow_mask    = '0;
        irq_cfg_i.overflow_mask[5] = 1'b1;
        selftest_i     = SELFTEST_ALL_ON;
        count_cfg_i.en = 1'b1;
        repeat (6) tick();
        count_cfg_i.en = 1'b0;
        // Vector register then interrupt register
        tick();
        tick();
        exp_vec    = '0;
        exp_vec[2] = 1'b1;
        exp_vec[5] = 1'b1;
        check_events("overflow_vect_o", exp_vec, overflow_vect_o);
        check_bit("intr_overflow_o", 1'b1, intr_overflow_o);
        irq_cfg_i.overflow_softrst = 1'b1;
        tick();
        irq_cfg_i.overflow_softrst = 1'b0;
        tick();
        check_events("overflow_vect_o", '0, overflow_vect_o);
        check_bit("intr_overflow_o", 1'b0, intr_overflow_o);
        // Counter 5 overflows again, now outside the mask
        irq_cfg_i.overflow_mask    = '0;
        irq_cfg_i.overflow_mask[2] = 1'b1;
        vals    = '0;
        vals[5] = NEAR_FULL;
        load_bank(vals);
        count_cfg_i.en = 1'b1;
        repeat (6) tick();
        count_cfg_i.en = 1'b0;
        tick();
        tick();
        exp_vec    = '0;
        exp_vec[5] = 1'b1;
        check_events("overflow_vect_o", exp_vec, overflow_vect_o);
        check_bit("intr_overflow_o", 1'b0, intr_overflow_o);
        irq_cfg_i.overflow_softrst = 1'b1;
        irq_cfg_i.overflow_en      = 1'b0;
        tick();
        irq_cfg_i.overflow_softrst = 1'b0;
        selftest_i = SELFTEST_OFF;
    endtask

    task automatic quota_irq();
        counter_vec_t vals;
        counter_t     sum;
        // Unmasked counters far above the limit
        for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
            vals[k] = counter_t'(5000);
        end
        vals[1] = counter_t'(100);
        vals[3] = counter_t'(200);
        vals[4] = counter_t'(300);
        sum = vals[1] + vals[3] + vals[4];
        load_bank(vals);
        irq_cfg_i.quota_mask    = '0;
        irq_cfg_i.quota_mask[1] = 1'b1;
        irq_cfg_i.quota_mask[3] = 1'b1;
        irq_cfg_i.quota_mask[4] = 1'b1;
        irq_cfg_i.quota_limit   = sum + counter_t'(1);
        repeat (3) tick();
        check_bit("intr_quota_o", 1'b0, intr_quota_o);
        // Three events on the line routed to counter 3
        count_cfg_i.en = 1'b1;
        events_i = soc_event_t'(1) << routed_line(3);
        repeat (3) tick();
        events_i = '0;
        tick();
        tick();
        count_cfg_i.en = 1'b0;
        check_counter("counters_o[3]", vals[3] + counter_t'(3), counters_o[3]);
        check_counter("counters_o[1]", vals[1], counters_o[1]);
        tick();
        check_bit("intr_quota_o", 1'b1, intr_quota_o);
        // Limit raised so the flag does not latch again
        irq_cfg_i.quota_softrst = 1'b1;
        irq_cfg_i.quota_limit   = counter_t'(1000);
        tick();
        irq_cfg_i.quota_softrst = 1'b0;
        tick();
        check_bit("intr_quota_o", 1'b0, intr_quota_o);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        lfsr_state  = 32'h3dfd;
        rstn_i      = 1'b0;
        events_i    = '0;
        xbar_cfg_i  = '0;
        selftest_i  = SELFTEST_OFF;
        count_cfg_i = '0;
        irq_cfg_i   = '0;
        we_i        = 1'b0;
        counters_i  = '0;
        repeat (16) tick();
        rstn_i = 1'b1;
        tick();
        verify_reset_state();
        crossbar_routing();
        selftest_modes();
        load_and_enable();
        overflow_irq();
        quota_irq();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/pmu_pkg.sv
hw/pmu_event_select.sv
hw/pmu_counters.sv
hw/pmu_irq.sv
hw/pmu_top.sv
tests/tb_pmu.sv
